// ==== core.sv ====
//################################################
// core
// five-stage in-order integer pipeline with
// instruction and data memory ports
//################################################
`timescale 1ns/1ps

module core (
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic                      v_inst,
  input  logic [core_pkg::xlen-1:0] inst,
  input  logic                      v_data,
  input  logic [core_pkg::xlen-1:0] data,
  output logic [core_pkg::xlen-1:0] pc,
  output logic                      v_pc,
  output logic                      v_mem,
  output logic                      mem_we,
  output logic [core_pkg::xlen-1:0] mem_addr,
  output logic [core_pkg::xlen-1:0] mem_data
);
  import core_pkg::*;

  ex_bus_if ex_bus ();
  result_if res ();

  logic                  stall;
  logic                  mem_stall;
  logic                  branch_taken;
  logic [xlen-1:0]       branch_target;
  inst_t                 if_inst;
  logic [xlen-1:0]       if_pc_plus4;
  logic [reg_addr_w-1:0] ex_dest;
  logic                  ex_reg_write;
  // EX/MEM fields
  logic                  em_reg_write;
  logic                  em_mem_to_reg;
  logic                  em_mem_read;
  logic                  em_mem_write;
  logic [xlen-1:0]       em_alu_result;
  logic [xlen-1:0]       em_store_data;
  logic [reg_addr_w-1:0] em_dest;

  fetch_stage u_fetch (
    .clk           (clk),
    .arst_n        (arst_n),
    .v_inst        (v_inst),
    .inst          (inst),
    .stall         (stall),
    .mem_stall     (mem_stall),
    .branch_taken  (branch_taken),
    .branch_target (branch_target),
    .pc            (pc),
    .v_pc          (v_pc),
    .if_inst       (if_inst),
    .if_pc_plus4   (if_pc_plus4)
  );

  decode_stage u_decode (
    .clk           (clk),
    .arst_n        (arst_n),
    .mem_stall     (mem_stall),
    .if_inst       (if_inst),
    .if_pc_plus4   (if_pc_plus4),
    .ex_dest       (ex_dest),
    .ex_reg_write  (ex_reg_write),
    .ex            (ex_bus.src),
    .res           (res.fwd),
    .stall         (stall),
    .branch_taken  (branch_taken),
    .branch_target (branch_target)
  );

  execute_stage u_execute (
    .clk           (clk),
    .arst_n        (arst_n),
    .mem_stall     (mem_stall),
    .ex            (ex_bus.dst),
    .res           (res.fwd),
    .ex_dest       (ex_dest),
    .ex_reg_write  (ex_reg_write),
    .em_reg_write  (em_reg_write),
    .em_mem_to_reg (em_mem_to_reg),
    .em_mem_read   (em_mem_read),
    .em_mem_write  (em_mem_write),
    .em_alu_result (em_alu_result),
    .em_store_data (em_store_data),
    .em_dest       (em_dest)
  );

  mem_wb_stage u_mem_wb (
    .clk           (clk),
    .arst_n        (arst_n),
    .v_data        (v_data),
    .data          (data),
    .em_reg_write  (em_reg_write),
    .em_mem_to_reg (em_mem_to_reg),
    .em_mem_read   (em_mem_read),
    .em_mem_write  (em_mem_write),
    .em_alu_result (em_alu_result),
    .em_store_data (em_store_data),
    .em_dest       (em_dest),
    .res           (res.src),
    .v_mem         (v_mem),
    .mem_we        (mem_we),
    .mem_addr      (mem_addr),
    .mem_data      (mem_data),
    .mem_stall     (mem_stall)
  );

endmodule

// ==== core_assertions.sv ====
//################################################
// core assertions
// data port hold rules and pc progression
//################################################
`timescale 1ns/1ps

module core_assertions (
  input logic                      clk,
  input logic                      arst_n,
  input logic                      v_inst,
  input logic                      v_data,
  input logic                      v_mem,
  input logic                      mem_we,
  input logic [core_pkg::xlen-1:0] pc,
  input logic [core_pkg::xlen-1:0] mem_addr,
  input logic [core_pkg::xlen-1:0] mem_data
);

  // request held until the data port answers
  assert property (@(posedge clk) disable iff (!arst_n)
    v_mem && !v_data |=> v_mem && $stable(mem_addr) && $stable(mem_data) && $stable(mem_we))
    else $error("data request changed while v_data was low");

  assert property (@(posedge clk) disable iff (!arst_n) mem_we |-> v_mem)
    else $error("mem_we high without v_mem");

  // pc moves only after an accepted fetch
  assert property (@(posedge clk) disable iff (!arst_n)
    $changed(pc) |-> $past(v_inst) && (pc == $past(pc) + 4 || pc[1:0] == 2'b00))
    else $error("pc changed without a valid fetch or to a bad address");

endmodule

// ==== core_pkg.sv ====
//################################################
// core_pkg
// widths, opcode and funct codes, ALU operation
// codes and the two views of the instruction word
//################################################
package core_pkg;

  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;

  // primary opcodes
  localparam logic [5:0] op_rtype = 6'h00;
  localparam logic [5:0] op_beq   = 6'h04;
  localparam logic [5:0] op_addi  = 6'h08;
  localparam logic [5:0] op_andi  = 6'h0c;
  localparam logic [5:0] op_ori   = 6'h0d;
  localparam logic [5:0] op_lw    = 6'h23;
  localparam logic [5:0] op_sw    = 6'h2b;

  // funct field of R-type
  localparam logic [5:0] fn_add = 6'h20;
  localparam logic [5:0] fn_sub = 6'h22;
  localparam logic [5:0] fn_and = 6'h24;
  localparam logic [5:0] fn_or  = 6'h25;
  localparam logic [5:0] fn_slt = 6'h2a;

  // ALU operations
  localparam logic [2:0] alu_add = 3'd0;
  localparam logic [2:0] alu_sub = 3'd1;
  localparam logic [2:0] alu_and = 3'd2;
  localparam logic [2:0] alu_or  = 3'd3;
  localparam logic [2:0] alu_slt = 3'd4;

  // same word, read as R-format or I-format
  typedef union packed {
    struct packed {
      logic [5:0] opcode;
      logic [4:0] rs;
      logic [4:0] rt;
      logic [4:0] rd;
      logic [4:0] shamt;
      logic [5:0] funct;
    } r;
    struct packed {
      logic [5:0]  opcode;
      logic [4:0]  rs;
      logic [4:0]  rt;
      logic [15:0] imm;
    } i;
  } inst_t;

  // all-zero word decodes to nothing
  localparam inst_t nop_word = '0;

endpackage

// ==== decode_stage.sv ====
//################################################
// decode stage
// control decode, beq compare, hazard detection
// and the ID/EX register
//################################################
`timescale 1ns/1ps

module decode_stage (
  input  logic                            clk,
  input  logic                            arst_n,
  input  logic                            mem_stall,
  input  core_pkg::inst_t                 if_inst,
  input  logic [core_pkg::xlen-1:0]       if_pc_plus4,
  input  logic [core_pkg::reg_addr_w-1:0] ex_dest,
  input  logic                            ex_reg_write,
  ex_bus_if.src                           ex,
  result_if.fwd                           res,
  output logic                            stall,
  output logic                            branch_taken,
  output logic [core_pkg::xlen-1:0]       branch_target
);
  import core_pkg::*;

  logic                  reg_write_d;
  logic                  mem_to_reg_d;
  logic                  mem_read_d;
  logic                  mem_write_d;
  logic [2:0]            alu_op_d;
  logic                  alu_src_imm_d;
  logic                  reg_dst_rd_d;
  logic                  is_beq;
  logic                  sign_ext;
  logic                  uses_rt;
  logic [reg_addr_w-1:0] rs;
  logic [reg_addr_w-1:0] rt;
  logic [xlen-1:0]       rs_rf;
  logic [xlen-1:0]       rt_rf;
  logic [xlen-1:0]       rs_cmp;
  logic [xlen-1:0]       rt_cmp;
  logic [xlen-1:0]       imm_ext;
  logic                  load_use;
  logic                  br_hazard;

  assign rs = if_inst.r.rs;
  assign rt = if_inst.r.rt;

  reg_file u_reg_file (
    .clk     (clk),
    .arst_n  (arst_n),
    .we      (res.wb_reg_write),
    .waddr   (res.wb_dest),
    .wdata   (res.wb_value),
    .raddr_a (rs),
    .raddr_b (rt),
    .rdata_a (rs_rf),
    .rdata_b (rt_rf)
  );

  always_comb begin
    reg_write_d   = 1'b0;
    mem_to_reg_d  = 1'b0;
    mem_read_d    = 1'b0;
    mem_write_d   = 1'b0;
    alu_op_d      = alu_add;
    alu_src_imm_d = 1'b1;
    reg_dst_rd_d  = 1'b0;
    is_beq        = 1'b0;
    sign_ext      = 1'b1;
    uses_rt       = 1'b0;
    case (if_inst.r.opcode)
      op_rtype: begin
        reg_dst_rd_d  = 1'b1;
        alu_src_imm_d = 1'b0;
        uses_rt       = 1'b1;
        reg_write_d   = 1'b1;
        case (if_inst.r.funct)
          fn_add:  alu_op_d = alu_add;
          fn_sub:  alu_op_d = alu_sub;
          fn_and:  alu_op_d = alu_and;
          fn_or:   alu_op_d = alu_or;
          fn_slt:  alu_op_d = alu_slt;
          // unknown funct, including nop_word
          default: reg_write_d = 1'b0;
        endcase
      end
      op_addi: reg_write_d = 1'b1;
      op_andi: begin
        reg_write_d = 1'b1;
        alu_op_d    = alu_and;
        sign_ext    = 1'b0;
      end
      op_ori: begin
        reg_write_d = 1'b1;
        alu_op_d    = alu_or;
        sign_ext    = 1'b0;
      end
      op_lw: begin
        reg_write_d  = 1'b1;
        mem_to_reg_d = 1'b1;
        mem_read_d   = 1'b1;
      end
      op_sw: begin
        mem_write_d = 1'b1;
        uses_rt     = 1'b1;
      end
      op_beq: begin
        is_beq  = 1'b1;
        uses_rt = 1'b1;
      end
      default: alu_src_imm_d = 1'b0;
    endcase
  end

  assign imm_ext = sign_ext ? {{16{if_inst.i.imm[15]}}, if_inst.i.imm}
                            : {16'b0, if_inst.i.imm};

  // EX/MEM result forwarded, WB comes in through the register file bypass
  assign rs_cmp = (res.mem_reg_write && res.mem_dest != '0 && res.mem_dest == rs)
                  ? res.mem_value : rs_rf;
  assign rt_cmp = (res.mem_reg_write && res.mem_dest != '0 && res.mem_dest == rt)
                  ? res.mem_value : rt_rf;

  // load in EX feeding this instruction
  assign load_use = ex.mem_read && ex.rt != '0 &&
                    (ex.rt == rs || (uses_rt && ex.rt == rt));

  // beq waits for any writer in EX and for a load in MEM
  assign br_hazard = is_beq &&
    ((ex_reg_write && ex_dest != '0 && (ex_dest == rs || ex_dest == rt)) ||
     (res.mem_is_load && res.mem_reg_write && res.mem_dest != '0 &&
      (res.mem_dest == rs || res.mem_dest == rt)));

  assign stall         = load_use || br_hazard;
  assign branch_taken  = is_beq && !stall && (rs_cmp == rt_cmp);
  assign branch_target = if_pc_plus4 + {imm_ext[xlen-3:0], 2'b00};

  // ID/EX control, bubble while stalled
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ex.reg_write  <= 1'b0;
      ex.mem_to_reg <= 1'b0;
      ex.mem_read   <= 1'b0;
      ex.mem_write  <= 1'b0;
    end else if (!mem_stall) begin
      ex.reg_write  <= reg_write_d && !stall;
      ex.mem_to_reg <= mem_to_reg_d && !stall;
      ex.mem_read   <= mem_read_d && !stall;
      ex.mem_write  <= mem_write_d && !stall;
    end
  end

  always_ff @(posedge clk) begin
    if (!mem_stall) begin
      ex.alu_op      <= alu_op_d;
      ex.alu_src_imm <= alu_src_imm_d;
      ex.reg_dst_rd  <= reg_dst_rd_d;
      ex.rs_val      <= rs_rf;
      ex.rt_val      <= rt_rf;
      ex.imm         <= imm_ext;
      ex.rs          <= rs;
      ex.rt          <= rt;
      ex.rd          <= if_inst.r.rd;
    end
  end

endmodule

// ==== execute_stage.sv ====
//################################################
// execute stage
// operand forwarding, ALU and the EX/MEM register
//################################################
`timescale 1ns/1ps

module execute_stage (
  input  logic                            clk,
  input  logic                            arst_n,
  input  logic                            mem_stall,
  ex_bus_if.dst                           ex,
  result_if.fwd                           res,
  output logic [core_pkg::reg_addr_w-1:0] ex_dest,
  output logic                            ex_reg_write,
  output logic                            em_reg_write,
  output logic                            em_mem_to_reg,
  output logic                            em_mem_read,
  output logic                            em_mem_write,
  output logic [core_pkg::xlen-1:0]       em_alu_result,
  output logic [core_pkg::xlen-1:0]       em_store_data,
  output logic [core_pkg::reg_addr_w-1:0] em_dest
);
  import core_pkg::*;

  logic [xlen-1:0] op_a;
  logic [xlen-1:0] rt_fwd;
  logic [xlen-1:0] op_b;
  logic [xlen-1:0] alu_result;

  // newest writer wins, MEM before WB before the ID/EX copy
  function automatic logic [xlen-1:0] pick(input logic [reg_addr_w-1:0] src,
                                           input logic [xlen-1:0]       id_val);
    logic [xlen-1:0] val;
    val = id_val;
    if (res.mem_reg_write && res.mem_dest != '0 && res.mem_dest == src) begin
      val = res.mem_value;
    end else if (res.wb_reg_write && res.wb_dest != '0 && res.wb_dest == src) begin
      val = res.wb_value;
    end
    return val;
  endfunction

  assign op_a   = pick(ex.rs, ex.rs_val);
  assign rt_fwd = pick(ex.rt, ex.rt_val);
  assign op_b   = ex.alu_src_imm ? ex.imm : rt_fwd;

  always_comb begin
    case (ex.alu_op)
      alu_sub: alu_result = op_a - op_b;
      alu_and: alu_result = op_a & op_b;
      alu_or:  alu_result = op_a | op_b;
      alu_slt: alu_result = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      default: alu_result = op_a + op_b;
    endcase
  end

  assign ex_dest      = ex.reg_dst_rd ? ex.rd : ex.rt;
  assign ex_reg_write = ex.reg_write;

  // EX/MEM
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      em_reg_write  <= 1'b0;
      em_mem_to_reg <= 1'b0;
      em_mem_read   <= 1'b0;
      em_mem_write  <= 1'b0;
    end else if (!mem_stall) begin
      em_reg_write  <= ex.reg_write;
      em_mem_to_reg <= ex.mem_to_reg;
      em_mem_read   <= ex.mem_read;
      em_mem_write  <= ex.mem_write;
    end
  end

  always_ff @(posedge clk) begin
    if (!mem_stall) begin
      em_alu_result <= alu_result;
      em_store_data <= rt_fwd;
      em_dest       <= ex_dest;
    end
  end

endmodule

// ==== fetch_stage.sv ====
//################################################
// fetch stage
// program counter, next-PC select and IF/ID
//################################################
`timescale 1ns/1ps

module fetch_stage (
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic                      v_inst,
  input  core_pkg::inst_t           inst,
  input  logic                      stall,
  input  logic                      mem_stall,
  input  logic                      branch_taken,
  input  logic [core_pkg::xlen-1:0] branch_target,
  output logic [core_pkg::xlen-1:0] pc,
  output logic                      v_pc,
  output core_pkg::inst_t           if_inst,
  output logic [core_pkg::xlen-1:0] if_pc_plus4
);
  import core_pkg::*;

  logic [xlen-1:0] pc_plus4;
  logic            advance;
  logic            fetch_go;

  assign pc_plus4 = pc + xlen'(4);
  assign advance  = !stall && !mem_stall;
  assign fetch_go = advance && v_inst;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc   <= '0;
      v_pc <= 1'b0;
    end else begin
      v_pc <= 1'b1;
      if (fetch_go) begin
        pc <= branch_taken ? branch_target : pc_plus4;
      end
    end
  end

  // IF/ID instruction
  // a taken beq with no fetch slot stays put until v_inst returns
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      if_inst <= nop_word;
    end else if (advance) begin
      if (fetch_go && !branch_taken) begin
        if_inst <= inst;
      end else if (fetch_go || !branch_taken) begin
        if_inst <= nop_word;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_go) begin
      if_pc_plus4 <= pc_plus4;
    end
  end

endmodule

// ==== files.f ====
core_pkg.sv
stage_ifs.sv
fetch_stage.sv
reg_file.sv
decode_stage.sv
execute_stage.sv
mem_wb_stage.sv
core.sv
core_assertions.sv
tb_core.sv

// ==== mem_wb_stage.sv ====
//################################################
// memory and writeback
// data memory request, MEM/WB and writeback mux
//################################################
`timescale 1ns/1ps

module mem_wb_stage (
  input  logic                            clk,
  input  logic                            arst_n,
  input  logic                            v_data,
  input  logic [core_pkg::xlen-1:0]       data,
  input  logic                            em_reg_write,
  input  logic                            em_mem_to_reg,
  input  logic                            em_mem_read,
  input  logic                            em_mem_write,
  input  logic [core_pkg::xlen-1:0]       em_alu_result,
  input  logic [core_pkg::xlen-1:0]       em_store_data,
  input  logic [core_pkg::reg_addr_w-1:0] em_dest,
  result_if.src                           res,
  output logic                            v_mem,
  output logic                            mem_we,
  output logic [core_pkg::xlen-1:0]       mem_addr,
  output logic [core_pkg::xlen-1:0]       mem_data,
  output logic                            mem_stall
);
  import core_pkg::*;

  logic                  wb_reg_write;
  logic                  wb_mem_to_reg;
  logic [reg_addr_w-1:0] wb_dest;
  logic [xlen-1:0]       wb_alu_result;
  logic [xlen-1:0]       wb_load_data;

  assign v_mem     = em_mem_read || em_mem_write;
  assign mem_we    = em_mem_write;
  assign mem_addr  = em_alu_result;
  assign mem_data  = em_store_data;
  // whole pipeline holds until the data port answers
  assign mem_stall = v_mem && !v_data;

  // MEM/WB
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wb_reg_write  <= 1'b0;
      wb_mem_to_reg <= 1'b0;
    end else if (!mem_stall) begin
      wb_reg_write  <= em_reg_write;
      wb_mem_to_reg <= em_mem_to_reg;
    end
  end

  always_ff @(posedge clk) begin
    if (!mem_stall) begin
      wb_dest       <= em_dest;
      wb_alu_result <= em_alu_result;
      wb_load_data  <= data;
    end
  end

  assign res.mem_reg_write = em_reg_write;
  assign res.mem_dest      = em_dest;
  assign res.mem_value     = em_alu_result;
  assign res.mem_is_load   = em_mem_read;
  assign res.wb_reg_write  = wb_reg_write;
  assign res.wb_dest       = wb_dest;
  assign res.wb_value      = wb_mem_to_reg ? wb_load_data : wb_alu_result;

endmodule

// ==== reg_file.sv ====
//################################################
// register file
// 32 x 32, r0 reads zero, write-before-read
//################################################
`timescale 1ns/1ps

module reg_file (
  input  logic                            clk,
  input  logic                            arst_n,
  input  logic                            we,
  input  logic [core_pkg::reg_addr_w-1:0] waddr,
  input  logic [core_pkg::xlen-1:0]       wdata,
  input  logic [core_pkg::reg_addr_w-1:0] raddr_a,
  input  logic [core_pkg::reg_addr_w-1:0] raddr_b,
  output logic [core_pkg::xlen-1:0]       rdata_a,
  output logic [core_pkg::xlen-1:0]       rdata_b
);
  import core_pkg::*;

  logic [xlen-1:0] regs [2**reg_addr_w];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < 2**reg_addr_w; i++) begin
        regs[i] <= '0;
      end
    end else if (we && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

  // bypass a same-cycle write
  assign rdata_a = (we && waddr != '0 && waddr == raddr_a) ? wdata : regs[raddr_a];
  assign rdata_b = (we && waddr != '0 && waddr == raddr_b) ? wdata : regs[raddr_b];

endmodule

// ==== stage_ifs.sv ====
//################################################
// stage interfaces
// ID/EX register contents and the results of the
// MEM and WB stages used for forwarding
//################################################
`timescale 1ns/1ps

interface ex_bus_if;
  import core_pkg::*;

  logic                  reg_write;
  logic                  mem_to_reg;
  logic                  mem_read;
  logic                  mem_write;
  logic [2:0]            alu_op;
  logic                  alu_src_imm;
  logic                  reg_dst_rd;
  logic [xlen-1:0]       rs_val;
  logic [xlen-1:0]       rt_val;
  logic [xlen-1:0]       imm;
  logic [reg_addr_w-1:0] rs;
  logic [reg_addr_w-1:0] rt;
  logic [reg_addr_w-1:0] rd;

  modport src (output reg_write, mem_to_reg, mem_read, mem_write, alu_op, alu_src_imm,
               reg_dst_rd, rs_val, rt_val, imm, rs, rt, rd);
  modport dst (input reg_write, mem_to_reg, mem_read, mem_write, alu_op, alu_src_imm,
               reg_dst_rd, rs_val, rt_val, imm, rs, rt, rd);
endinterface

interface result_if;
  import core_pkg::*;

  // instruction sitting in EX/MEM
  logic                  mem_reg_write;
  logic [reg_addr_w-1:0] mem_dest;
  logic [xlen-1:0]       mem_value;
  logic                  mem_is_load;
  // instruction sitting in MEM/WB
  logic                  wb_reg_write;
  logic [reg_addr_w-1:0] wb_dest;
  logic [xlen-1:0]       wb_value;

  modport src (output mem_reg_write, mem_dest, mem_value, mem_is_load,
               wb_reg_write, wb_dest, wb_value);
  modport fwd (input mem_reg_write, mem_dest, mem_value, mem_is_load,
               wb_reg_write, wb_dest, wb_value);
endinterface

// ==== tb_core.sv ====
//################################################
// core testbench
// memory models, directed programs and store checks
//################################################
`timescale 1ns/1ps

module tb_core;
  import core_pkg::*;

  // 5 runs of at most 16 instructions with room for random gaps
  localparam int watchdog_cycles = 2000;
  localparam int store_wait_max  = 500;

  logic            clk;
  logic            arst_n;
  logic            v_inst;
  logic            v_data;
  logic [xlen-1:0] inst;
  logic [xlen-1:0] data;
  logic [xlen-1:0] pc;
  logic            v_pc;
  logic            v_mem;
  logic            mem_we;
  logic [xlen-1:0] mem_addr;
  logic [xlen-1:0] mem_data;
  logic            gaps;

  logic [xlen-1:0] imem [256];
  logic [xlen-1:0] dmem [256];
  logic [xlen-1:0] st_addr [$];
  logic [xlen-1:0] st_data [$];
  logic [xlen-1:0] exp_addr [$];
  logic [xlen-1:0] exp_data [$];

  core UUT (
    .clk (clk), .arst_n (arst_n), .v_inst (v_inst), .inst (inst),
    .v_data (v_data), .data (data), .pc (pc), .v_pc (v_pc),
    .v_mem (v_mem), .mem_we (mem_we), .mem_addr (mem_addr), .mem_data (mem_data)
  );

  bind core core_assertions u_core_assertions (
    .clk (clk), .arst_n (arst_n), .v_inst (v_inst), .v_data (v_data), .v_mem (v_mem),
    .mem_we (mem_we), .pc (pc), .mem_addr (mem_addr), .mem_data (mem_data)
  );

  always #5 clk = ~clk;

  // both memories answer at the falling edge
  always @(negedge clk) begin
    v_inst = gaps ? ($urandom_range(3) != 0) : 1'b1;
    v_data = gaps ? ($urandom_range(2) != 0) : 1'b1;
    inst   = v_inst ? imem[pc[9:2]] : 32'hffff_ffff;
    data   = dmem[mem_addr[9:2]];
    // record each store the data port accepts
    if (v_mem && mem_we && v_data) begin
      st_addr.push_back(mem_addr);
      st_data.push_back(mem_data);
      dmem[mem_addr[9:2]] = mem_data;
    end
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_word(input string name, input logic [xlen-1:0] got, exp);
    if (got !== exp) begin
      report_failure($sformatf("Fail at %0t: %s = %h, expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, exp);
    if (got !== exp) begin
      report_failure($sformatf("Fail at %0t: %s = %b, expected %b", $time, name, got, exp));
    end
  endtask

  function automatic inst_t r_word(input logic [5:0] fn, input logic [4:0] rd, rs, rt);
    inst_t w;
    w = nop_word;
    w.r.opcode = op_rtype;
    w.r.rs = rs;
    w.r.rt = rt;
    w.r.rd = rd;
    w.r.funct = fn;
    return w;
  endfunction

  // arguments in assembly order op rt rs imm
  function automatic inst_t i_word(input logic [5:0] op, input logic [4:0] rt, rs,
                                   input logic [15:0] imm);
    inst_t w;
    w.i.opcode = op;
    w.i.rs = rs;
    w.i.rt = rt;
    w.i.imm = imm;
    return w;
  endfunction

  task automatic expect_store(input logic [xlen-1:0] addr, input logic [xlen-1:0] value);
    exp_addr.push_back(addr);
    exp_data.push_back(value);
  endtask

  task automatic start_test;
    for (int i = 0; i < 256; i++) begin
      imem[i] = nop_word;
      dmem[i] = {i[15:0], ~i[15:0]};
    end
    st_addr.delete();
    st_data.delete();
    exp_addr.delete();
    exp_data.delete();
  endtask

  task automatic apply_reset;
    @(negedge clk);
    arst_n = 1'b0;
    repeat (5) @(negedge clk);
    check_word("pc", pc, '0);
    check_bit("v_pc", v_pc, 1'b0);
    check_bit("v_mem", v_mem, 1'b0);
    check_bit("mem_we", mem_we, 1'b0);
    arst_n = 1'b1;
  endtask

  // wait for every expected store then drain to catch extra ones
  task automatic check_stores;
    int n;
    n = 0;
    while (st_addr.size() < exp_addr.size()) begin
      @(negedge clk);
      n++;
      if (n > store_wait_max) begin
        report_failure($sformatf("missing store: only %0d of %0d reached the data port",
                                 st_addr.size(), exp_addr.size()));
      end
    end
    repeat (20) @(negedge clk);
    for (int k = 0; k < exp_addr.size(); k++) begin
      check_word($sformatf("mem_addr of store %0d", k), st_addr[k], exp_addr[k]);
      check_word($sformatf("mem_data of store %0d", k), st_data[k], exp_data[k]);
    end
    if (st_addr.size() != exp_addr.size()) begin
      report_failure("the core issued more stores than the program holds");
    end
  endtask

  task automatic reset_test;
    start_test();
    apply_reset();
    @(negedge clk);
    check_word("pc", pc, 32'd4);
    check_bit("v_pc", v_pc, 1'b1);
    check_bit("v_mem", v_mem, 1'b0);
  endtask

  // dependencies at distance 1, 2 and 3
  task automatic load_alu_program;
    imem[0]  = i_word(op_addi, 5'd1, 5'd0, 16'h000f);
    imem[1]  = i_word(op_ori, 5'd2, 5'd1, 16'h0030);
    imem[2]  = r_word(fn_sub, 5'd3, 5'd2, 5'd1);
    imem[3]  = r_word(fn_or, 5'd4, 5'd3, 5'd1);
    imem[4]  = r_word(fn_add, 5'd5, 5'd2, 5'd4);
    imem[5]  = i_word(op_andi, 5'd6, 5'd5, 16'h000f);
    imem[6]  = r_word(fn_slt, 5'd7, 5'd6, 5'd5);
    imem[7]  = i_word(op_addi, 5'd8, 5'd0, 16'hffff);
    imem[8]  = r_word(fn_slt, 5'd9, 5'd8, 5'd7);
    imem[9]  = i_word(op_sw, 5'd9, 5'd0, 16'h0000);
    imem[10] = i_word(op_sw, 5'd3, 5'd0, 16'h0004);
    imem[11] = i_word(op_sw, 5'd4, 5'd0, 16'h0008);
    imem[12] = i_word(op_sw, 5'd5, 5'd0, 16'h000c);
    imem[13] = i_word(op_sw, 5'd6, 5'd0, 16'h0010);
    imem[14] = i_word(op_sw, 5'd8, 5'd0, 16'h0014);
    imem[15] = i_word(op_sw, 5'd7, 5'd0, 16'h0018);
    // signed slt gives -1 < 1
    expect_store(32'h00, 32'h1);
    expect_store(32'h04, 32'h30);
    expect_store(32'h08, 32'h3f);
    expect_store(32'h0c, 32'h7e);
    expect_store(32'h10, 32'h0e);
    expect_store(32'h14, 32'hffff_ffff);
    expect_store(32'h18, 32'h1);
  endtask

  task automatic alu_forwarding_test;
    start_test();
    load_alu_program();
    apply_reset();
    check_stores();
  endtask

  task automatic load_use_test;
    start_test();
    dmem[16] = 32'h1234_0000;
    dmem[17] = 32'h0000_0080;
    imem[0] = i_word(op_addi, 5'd1, 5'd0, 16'h0040);
    imem[1] = i_word(op_addi, 5'd2, 5'd0, 16'h0055);
    imem[2] = i_word(op_lw, 5'd3, 5'd1, 16'h0000);
    imem[3] = r_word(fn_add, 5'd4, 5'd3, 5'd2);
    imem[4] = i_word(op_sw, 5'd4, 5'd0, 16'h0100);
    imem[5] = i_word(op_lw, 5'd5, 5'd1, 16'h0004);
    imem[6] = i_word(op_sw, 5'd2, 5'd5, 16'h0000);
    imem[7] = i_word(op_lw, 5'd6, 5'd0, 16'h0100);
    imem[8] = i_word(op_sw, 5'd6, 5'd5, 16'h0004);
    expect_store(32'h100, 32'h1234_0055);
    expect_store(32'h80, 32'h55);
    expect_store(32'h84, 32'h1234_0055);
    apply_reset();
    check_stores();
  endtask

  task automatic branch_test;
    start_test();
    imem[0]  = i_word(op_addi, 5'd1, 5'd0, 16'h0007);
    imem[1]  = i_word(op_addi, 5'd2, 5'd0, 16'h0007);
    imem[2]  = i_word(op_beq, 5'd2, 5'd1, 16'h0001);
    imem[3]  = i_word(op_sw, 5'd1, 5'd0, 16'h0200);
    imem[4]  = i_word(op_sw, 5'd2, 5'd0, 16'h0204);
    imem[5]  = i_word(op_addi, 5'd3, 5'd0, 16'h0009);
    // a stale r3 would equal r0 and take the branch
    imem[6]  = i_word(op_beq, 5'd0, 5'd3, 16'h0001);
    imem[7]  = i_word(op_sw, 5'd3, 5'd0, 16'h0208);
    imem[8]  = i_word(op_lw, 5'd4, 5'd0, 16'h0204);
    imem[9]  = i_word(op_beq, 5'd1, 5'd4, 16'h0001);
    imem[10] = i_word(op_sw, 5'd0, 5'd0, 16'h020c);
    imem[11] = i_word(op_sw, 5'd4, 5'd0, 16'h0210);
    // stores at 0x200 and 0x20c sit behind taken branches
    expect_store(32'h204, 32'h7);
    expect_store(32'h208, 32'h9);
    expect_store(32'h210, 32'h7);
    apply_reset();
    check_stores();
  endtask

  task automatic random_gap_test;
    start_test();
    load_alu_program();
    gaps = 1'b1;
    apply_reset();
    check_stores();
    gaps = 1'b0;
  endtask

  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    report_failure("watchdog expired before the tests finished");
  end

  initial begin
    void'($urandom(32'hd239));
    clk    = 1'b0;
    arst_n = 1'b0;
    v_inst = 1'b0;
    v_data = 1'b0;
    inst   = '0;
    data   = '0;
    gaps   = 1'b0;
    reset_test();
    alu_forwarding_test();
    load_use_test();
    branch_test();
    random_gap_test();
    $display("Result: PASSED");
    $finish;
  end

endmodule
